// ==== common/disc_pkg.sv ====
`default_nettype none

package disc_pkg;

    // bytes in one disc or memory line
    localparam int line_bytes = 16;

    // one line of disc or main memory, byte 0 in bits 7:0
    typedef logic [8*line_bytes-1:0] line_t;

    // byte address into the 512-byte disc
    typedef logic [8:0] disc_addr_t;

    // line index into main memory
    typedef logic [3:0] mem_line_t;

    // transfer command from the host
    typedef struct packed {
        disc_addr_t disc_addr;
        mem_line_t  mem_line;
        // 1 to 16 lines
        logic [4:0] line_count;
    } dma_cmd_t;

    // fetch request from the engine to the disc unit
    typedef struct packed {
        disc_addr_t addr;
    } disc_fetch_t;

endpackage

`default_nettype wire

// ==== disc/byte_align.sv ====
`timescale 1ns/10ps
`default_nettype none

module byte_align (
    input  logic [3:0]      offset,
    input  disc_pkg::line_t cur,
    input  disc_pkg::line_t next,
    output disc_pkg::line_t data
);

    // one extra bit tells whether a source byte lies in next
    localparam int sel_w = $clog2(disc_pkg::line_bytes) + 1;

    for (genvar j = 0; j < disc_pkg::line_bytes; j++) begin : g_byte
        logic [sel_w-1:0] src;

        // source byte position counted across cur then next
        assign src = {1'b0, offset} + sel_w'(j);

        assign data[8*j +: 8] = src[sel_w-1] ? next[8*src[sel_w-2:0] +: 8]
                                              : cur[8*src[sel_w-2:0] +: 8];
    end

endmodule

`default_nettype wire

// ==== disc/disc_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

module disc_unit #(
    parameter int disc_lines  = 32,
    parameter int seek_cycles = 40
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    fetch_req,
    input  disc_pkg::disc_fetch_t   fetch,
    output logic                    fetch_ack,
    output disc_pkg::line_t         fetch_data
);

    localparam int line_w = $clog2(disc_lines);
    localparam int offs_w = $clog2(disc_pkg::line_bytes);
    localparam int cnt_w  = $clog2(seek_cycles + 1);

    typedef enum logic [2:0] {
        st_idle,
        st_seek,
        st_read,
        st_ack,
        st_wait_low
    } state_t;

    state_t state;

    disc_pkg::line_t lines [disc_lines];

    // set once the head has moved after reset
    logic               head_ready;
    logic [cnt_w-1:0]   seek_cnt;

    logic [line_w-1:0]  cur_idx;
    logic [line_w-1:0]  next_idx;
    disc_pkg::line_t    cur_line;
    disc_pkg::line_t    next_line;
    logic [offs_w-1:0]  offset;

    initial begin
        $readmemh("test/disc.hex", lines);
    end

    // successor wraps at the last disc line
    assign cur_idx  = fetch.addr[offs_w +: line_w];
    assign next_idx = cur_idx + 1'b1;

    always_ff @(posedge clk) begin
        if (!rst) begin
            state      <= st_idle;
            head_ready <= 1'b0;
            seek_cnt   <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (fetch_req) begin
                        if (head_ready) begin
                            state <= st_read;
                        end else begin
                            seek_cnt <= cnt_w'(seek_cycles - 1);
                            state    <= st_seek;
                        end
                    end
                end
                st_seek: begin
                    if (seek_cnt == '0) begin
                        head_ready <= 1'b1;
                        state      <= st_read;
                    end else begin
                        seek_cnt <= seek_cnt - 1'b1;
                    end
                end
                st_read: state <= st_ack;
                // hold the line until the engine lets go
                st_ack: begin
                    if (!fetch_req) begin
                        state <= st_wait_low;
                    end
                end
                st_wait_low: begin
                    if (!fetch_req) begin
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // two adjacent lines and the byte offset into the first
    always_ff @(posedge clk) begin
        if (state == st_read) begin
            cur_line  <= lines[cur_idx];
            next_line <= lines[next_idx];
            offset    <= fetch.addr[offs_w-1:0];
        end
    end

    assign fetch_ack = (state == st_ack);

    byte_align byte_align_i (
        .offset (offset),
        .cur    (cur_line),
        .next   (next_line),
        .data   (fetch_data)
    );

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# compile and run the disc DMA testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module disc_dma_tb \
    -f verilog.f \
    -o disc_dma_sim

output=$(./obj_dir/disc_dma_sim 2>&1) || true
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qx "test passed"; then
    exit 0
fi
exit 1

// ==== source/disc_dma_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module disc_dma_top #(
    parameter int disc_lines  = 32,
    parameter int mem_lines   = 16,
    parameter int seek_cycles = 40
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    cmd_req,
    input  disc_pkg::dma_cmd_t      cmd,
    output logic                    cmd_ack,
    input  disc_pkg::mem_line_t     rd_line,
    output disc_pkg::line_t         rd_data
);

    // engine to disc
    logic                   fetch_req;
    disc_pkg::disc_fetch_t  fetch;
    logic                   fetch_ack;
    disc_pkg::line_t        fetch_data;

    // engine to memory
    logic                   mem_we;
    disc_pkg::mem_line_t    mem_waddr;
    disc_pkg::line_t        mem_wdata;

    dma_engine dma_engine_i (
        .clk        (clk),
        .rst        (rst),
        .cmd_req    (cmd_req),
        .cmd        (cmd),
        .cmd_ack    (cmd_ack),
        .fetch_req  (fetch_req),
        .fetch      (fetch),
        .fetch_ack  (fetch_ack),
        .fetch_data (fetch_data),
        .mem_we     (mem_we),
        .mem_waddr  (mem_waddr),
        .mem_wdata  (mem_wdata)
    );

    disc_unit #(
        .disc_lines  (disc_lines),
        .seek_cycles (seek_cycles)
    ) disc_unit_i (
        .clk        (clk),
        .rst        (rst),
        .fetch_req  (fetch_req),
        .fetch      (fetch),
        .fetch_ack  (fetch_ack),
        .fetch_data (fetch_data)
    );

    main_mem #(
        .mem_lines (mem_lines)
    ) main_mem_i (
        .clk     (clk),
        .we      (mem_we),
        .waddr   (mem_waddr),
        .wdata   (mem_wdata),
        .rd_line (rd_line),
        .rd_data (rd_data)
    );

endmodule

`default_nettype wire

// ==== source/dma_engine.sv ====
`timescale 1ns/10ps
`default_nettype none

module dma_engine (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    cmd_req,
    input  disc_pkg::dma_cmd_t      cmd,
    output logic                    cmd_ack,
    output logic                    fetch_req,
    output disc_pkg::disc_fetch_t   fetch,
    input  logic                    fetch_ack,
    input  disc_pkg::line_t         fetch_data,
    output logic                    mem_we,
    output disc_pkg::mem_line_t     mem_waddr,
    output disc_pkg::line_t         mem_wdata
);

    typedef enum logic [2:0] {
        st_idle,
        st_fetch,
        st_release,
        st_done
    } state_t;

    state_t state;

    // running position within the command
    disc_pkg::disc_addr_t   disc_addr;
    disc_pkg::mem_line_t    mem_line;
    logic [4:0]             remaining;

    assign fetch = disc_pkg::disc_fetch_t'{addr: disc_addr};

    always_ff @(posedge clk) begin
        if (!rst) begin
            state     <= st_idle;
            cmd_ack   <= 1'b0;
            fetch_req <= 1'b0;
            mem_we    <= 1'b0;
            disc_addr <= '0;
            mem_line  <= '0;
            remaining <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (cmd_req) begin
                        disc_addr <= cmd.disc_addr;
                        mem_line  <= cmd.mem_line;
                        remaining <= cmd.line_count;
                        fetch_req <= 1'b1;
                        state     <= st_fetch;
                    end
                end
                st_fetch: begin
                    if (fetch_ack) begin
                        // write the line next cycle and step on
                        fetch_req <= 1'b0;
                        mem_we    <= 1'b1;
                        disc_addr <= disc_addr +
                                     disc_pkg::disc_addr_t'(disc_pkg::line_bytes);
                        mem_line  <= mem_line + 1'b1;
                        remaining <= remaining - 1'b1;
                        state     <= st_release;
                    end
                end
                st_release: begin
                    mem_we <= 1'b0;
                    // disc must be back to idle before the next fetch
                    if (!fetch_ack) begin
                        if (remaining == '0) begin
                            cmd_ack <= 1'b1;
                            state   <= st_done;
                        end else begin
                            fetch_req <= 1'b1;
                            state     <= st_fetch;
                        end
                    end
                end
                st_done: begin
                    // ack stays high while the host keeps req high
                    if (!cmd_req) begin
                        cmd_ack <= 1'b0;
                        state   <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // write payload taken while the disc holds its data
    always_ff @(posedge clk) begin
        if (state == st_fetch && fetch_ack) begin
            mem_waddr <= mem_line;
            mem_wdata <= fetch_data;
        end
    end

endmodule

`default_nettype wire

// ==== source/main_mem.sv ====
`timescale 1ns/10ps
`default_nettype none

module main_mem #(
    parameter int mem_lines = 16
) (
    input  logic                    clk,
    input  logic                    we,
    input  disc_pkg::mem_line_t     waddr,
    input  disc_pkg::line_t         wdata,
    input  disc_pkg::mem_line_t     rd_line,
    output disc_pkg::line_t         rd_data
);

    disc_pkg::line_t mem_array [mem_lines];

    // engine write port
    always_ff @(posedge clk) begin
        if (we) begin
            mem_array[waddr] <= wdata;
        end
    end

    // host read port, one cycle latency
    always_ff @(posedge clk) begin
        rd_data <= mem_array[rd_line];
    end

endmodule

`default_nettype wire

// ==== test/disc.hex ====
// one 128-bit disc line per row, line 0 first
// byte 15 of the line on the left, byte 0 on the right
3611ecc7a27d58330ee9c49f7a55300b
86613c17f2cda8835e3914efcaa5805b
d6b18c67421df8d3ae89643f1af5d0ab
2601dcb7926d4823fed9b48f6a4520fb
76512c07e2bd98734e2904dfba95704b
c6a17c57320de8c39e79542f0ae5c09b
16f1cca7825d3813eec9a47f5a3510eb
66411cf7d2ad88633e19f4cfaa85603b
b6916c4722fdd8b38e69441ffad5b08b
06e1bc97724d2803deb9946f4a2500db
56310ce7c29d78532e09e4bf9a75502b
a6815c3712edc8a37e59340feac5a07b
f6d1ac87623d18f3cea9845f3a15f0cb
4621fcd7b28d68431ef9d4af8a65401b
96714c2702ddb8936e4924ffdab5906b
e6c19c77522d08e3be99744f2a05e0bb
3611ecc7a27d58330ee9c49f7a55300b
86613c17f2cda8835e3914efcaa5805b
d6b18c67421df8d3ae89643f1af5d0ab
2601dcb7926d4823fed9b48f6a4520fb
76512c07e2bd98734e2904dfba95704b
c6a17c57320de8c39e79542f0ae5c09b
16f1cca7825d3813eec9a47f5a3510eb
66411cf7d2ad88633e19f4cfaa85603b
b6916c4722fdd8b38e69441ffad5b08b
06e1bc97724d2803deb9946f4a2500db
56310ce7c29d78532e09e4bf9a75502b
a6815c3712edc8a37e59340feac5a07b
f6d1ac87623d18f3cea9845f3a15f0cb
4621fcd7b28d68431ef9d4af8a65401b
96714c2702ddb8936e4924ffdab5906b
e6c19c77522d08e3be99744f2a05e0bb

// ==== test/disc_dma_properties.sv ====
`timescale 1ns/10ps
`default_nettype none

module disc_dma_properties (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    cmd_req,
    input  logic                    cmd_ack,
    input  logic                    fetch_req,
    input  disc_pkg::disc_fetch_t   fetch,
    input  logic                    fetch_ack,
    input  logic                    mem_we
);

    // ack only answers a host request plus one cycle after req drops
    ack_needs_req: assert property (@(posedge clk) disable iff (!rst)
        cmd_ack |-> (cmd_req || $past(cmd_req)))
        else $error("cmd_ack high without cmd_req");

    fetch_stable: assert property (@(posedge clk) disable iff (!rst)
        (fetch_req && $past(fetch_req)) |-> $stable(fetch))
        else $error("fetch changed while fetch_req was high");

    // new request only once the disc has let go
    req_after_ack_low: assert property (@(posedge clk) disable iff (!rst)
        $rose(fetch_req) |-> !fetch_ack)
        else $error("fetch_req rose while fetch_ack was high");

    we_single_pulse: assert property (@(posedge clk) disable iff (!rst)
        mem_we |-> ($past(fetch_ack) && !$past(mem_we)))
        else $error("mem_we not a single pulse after fetch_ack");

endmodule

bind dma_engine disc_dma_properties disc_dma_properties_i (
    .clk       (clk),
    .rst       (rst),
    .cmd_req   (cmd_req),
    .cmd_ack   (cmd_ack),
    .fetch_req (fetch_req),
    .fetch     (fetch),
    .fetch_ack (fetch_ack),
    .mem_we    (mem_we)
);

`default_nettype wire

// ==== test/disc_dma_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module disc_dma_tb;

    localparam int disc_lines  = 32;
    localparam int mem_lines   = 16;
    localparam int seek_cycles = 40;
    localparam int n_tests     = 6;

    logic                   clk;
    logic                   rst;
    logic                   cmd_req;
    disc_pkg::dma_cmd_t     cmd;
    logic                   cmd_ack;
    disc_pkg::mem_line_t    rd_line;
    disc_pkg::line_t        rd_data;

    // command table
    string                  test_name [n_tests];
    disc_pkg::dma_cmd_t     test_cmd  [n_tests];
    logic                   hold_host [n_tests];

    // expected memory contents
    disc_pkg::line_t        shadow  [mem_lines];
    logic                   written [mem_lines];

    int                     value_errors;
    int                     other_errors;
    int unsigned            seed_val;
    int                     gap;
    int                     t;

    disc_dma_top #(
        .disc_lines  (disc_lines),
        .mem_lines   (mem_lines),
        .seek_cycles (seek_cycles)
    ) disc_dma_top_i (
        .clk     (clk),
        .rst     (rst),
        .cmd_req (cmd_req),
        .cmd     (cmd),
        .cmd_ack (cmd_ack),
        .rd_line (rd_line),
        .rd_data (rd_data)
    );

    always #2 clk = ~clk;

    // disc byte k holds (k*37 + 11) mod 256
    function automatic logic [7:0] disc_byte(input int k);
        return 8'(((k % 512) * 37 + 11) % 256);
    endfunction

    // line i of a command starting at disc byte base
    function automatic disc_pkg::line_t transfer_line(input int base, input int i);
        disc_pkg::line_t l;
        for (int j = 0; j < disc_pkg::line_bytes; j++) begin
            l[8*j +: 8] = disc_byte((base + 16*i + j) % 512);
        end
        return l;
    endfunction

    task automatic set_entry(input int idx, input string name, input int addr,
                             input int mline, input int count, input logic hold);
        test_name[idx]            = name;
        test_cmd[idx].disc_addr   = disc_pkg::disc_addr_t'(addr);
        test_cmd[idx].mem_line    = disc_pkg::mem_line_t'(mline);
        test_cmd[idx].line_count  = 5'(count);
        hold_host[idx]            = hold;
    endtask

    task automatic load_table();
        set_entry(0, "aligned_seek",   9'h000,  0, 1, 1'b0);
        set_entry(1, "unaligned_off5", 9'h025,  3, 1, 1'b0);
        set_entry(2, "multi_off13",    9'h06d,  5, 6, 1'b0);
        // disc and memory indices both wrap
        set_entry(3, "wrap_disc_mem",  9'h1f4, 14, 3, 1'b0);
        // line 5 above the held command was written earlier
        set_entry(4, "host_hold",      9'h100,  4, 1, 1'b1);
        set_entry(5, "after_hold",     9'h0b7, 11, 2, 1'b0);
    endtask

    task automatic record_command(input int n);
        int idx;
        for (int i = 0; i < int'(test_cmd[n].line_count); i++) begin
            idx = (int'(test_cmd[n].mem_line) + i) % mem_lines;
            shadow[idx]  = transfer_line(int'(test_cmd[n].disc_addr), i);
            written[idx] = 1'b1;
        end
    endtask

    // four-phase handshake with the engine
    task automatic run_command(input int n);
        int hold_cycles;
        cmd_req <= 1'b1;
        cmd     <= test_cmd[n];
        @(posedge clk);
        while (!cmd_ack) @(posedge clk);
        if (hold_host[n]) begin
            hold_cycles = 2 + int'($urandom % 7);
            repeat (hold_cycles) begin
                @(posedge clk);
                assert (cmd_ack === 1'b1) else begin
                    $display("cmd_ack dropped while the host still held cmd_req in %s",
                             test_name[n]);
                    other_errors++;
                end
            end
        end
        cmd_req <= 1'b0;
        @(posedge clk);
        while (cmd_ack) @(posedge clk);
        record_command(n);
    endtask

    task automatic check_line(input string name, input int idx);
        rd_line <= disc_pkg::mem_line_t'(idx);
        @(posedge clk);
        @(posedge clk);
        assert (rd_data === shadow[idx]) else begin
            $display("ERR %s mem line %0d: expected %h, actual %h",
                     name, idx, shadow[idx], rd_data);
            value_errors++;
        end
    endtask

    task automatic check_command(input int n);
        int idx;
        if (hold_host[n]) begin
            // every line written so far must be untouched
            for (int m = 0; m < mem_lines; m++) begin
                if (written[m]) begin
                    check_line(test_name[n], m);
                end
            end
        end else begin
            for (int i = 0; i < int'(test_cmd[n].line_count); i++) begin
                idx = (int'(test_cmd[n].mem_line) + i) % mem_lines;
                check_line(test_name[n], idx);
            end
        end
    endtask

    initial begin
        clk          = 1'b0;
        rst          <= 1'b0;
        cmd_req      <= 1'b0;
        cmd          <= '0;
        rd_line      <= '0;
        value_errors = 0;
        other_errors = 0;
        for (int m = 0; m < mem_lines; m++) begin
            written[m] = 1'b0;
            shadow[m]  = '0;
        end
        load_table();
        seed_val = $urandom(32'ha43abcc7);

        repeat (5) @(posedge clk);
        rst <= 1'b1;

        for (t = 0; t < n_tests; t++) begin
            gap = int'($urandom % 4);
            repeat (gap) @(posedge clk);
            run_command(t);
            check_command(t);
        end

        $display("errors: %0d value, %0d other", value_errors, other_errors);
        if (value_errors + other_errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    initial begin : watchdog
        int limit;
        int total_lines;
        @(posedge clk);
        total_lines = 0;
        for (int i = 0; i < n_tests; i++) begin
            total_lines += int'(test_cmd[i].line_count);
        end
        limit = seek_cycles + 10 * total_lines + 20 * n_tests;
        repeat (limit) @(posedge clk);
        $display("transfer hung, the run did not finish within %0d cycles", limit);
        $display("test failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
common/disc_pkg.sv
disc/byte_align.sv
disc/disc_unit.sv
source/dma_engine.sv
source/main_mem.sv
source/disc_dma_top.sv
test/disc_dma_properties.sv
test/disc_dma_tb.sv
